//--- arcade_io_top.f
hdl/arcade_input_pkg.sv
hdl/arcade_av_pkg.sv
hdl/clk_enables.sv
hdl/ps2_key_decoder.sv
hdl/button_latch.sv
hdl/control_mapper.sv
hdl/video_blank.sv
hdl/sigma_delta_dac.sv
hdl/arcade_io_top.sv
tb/arcade_io_props.sv
tb/arcade_io_tb.sv

//--- Makefile
TOP   := arcade_io_tb
FLIST := arcade_io_top.f

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): $(FLIST) hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f $(FLIST)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FLIST)
	verilator --lint-only -Wall --top-module arcade_io_top \
		hdl/arcade_input_pkg.sv hdl/arcade_av_pkg.sv hdl/clk_enables.sv \
		hdl/ps2_key_decoder.sv hdl/button_latch.sv hdl/control_mapper.sv \
		hdl/video_blank.sv hdl/sigma_delta_dac.sv hdl/arcade_io_top.sv

clean:
	rm -rf obj_dir

//--- tb/arcade_io_tb.sv
module arcade_io_tb
	import arcade_input_pkg::*, arcade_av_pkg::*;
();

	localparam int TEST_CYCLES = 2 + 240 + 200 * 3 + 100 + 300 + 3 * (2 + 1024) + 100;

	logic          clk_sys;
	logic          reset;
	logic          reset_req;
	logic          menu_reset;
	logic          rotate;
	ps2_key_t      ps2_key;
	joy_t          joy0;
	joy_t          joy1;
	core_color_t   core_r, core_g, core_b;
	logic          core_hs, core_vs, core_hblank, core_vblank;
	audio_t        audio_in;
	logic          ce_pix, ce_star, ce_snd;
	core_buttons_t core_buttons;
	logic          core_reset;
	out_color_t    vga_r, vga_g, vga_b;
	logic          vga_hs, vga_vs;
	logic          audio_l, audio_r;

	// Reference model state
	int               pix_k;
	int               snd_k;
	logic             exp_pix, exp_star, exp_snd, exp_core_reset;
	out_color_t       exp_r, exp_g, exp_b;
	logic             exp_hs, exp_vs;
	logic [AUDIO_W:0] acc_model;
	button_vec_t      flags;  // Held keyboard buttons
	logic [15:0]      lfsr;

	arcade_io_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic report_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compare_buttons(input string name, input core_buttons_t got,
			input core_buttons_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic compare_color(input string name, input out_color_t got, input out_color_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			report_failure();
		end
	endtask

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Scan code per button, in button order
	function automatic logic [7:0] code_for(input int i);
		case (i)
			0:       return KEY_UP;
			1:       return KEY_DOWN;
			2:       return KEY_LEFT;
			3:       return KEY_RIGHT;
			4:       return KEY_ESC;
			5:       return KEY_F1;
			6:       return KEY_F2;
			7:       return KEY_SPACE;
			8:       return KEY_ALT;
			default: return KEY_CTRL;
		endcase
	endfunction

	function automatic core_buttons_t expected_buttons(input button_vec_t f, input joy_t j0,
			input joy_t j1, input logic rot);
		logic          up, down, left, right;
		core_buttons_t w;
		up    = f[BTN_UP]    | j0[JOY_UP]    | j1[JOY_UP];
		down  = f[BTN_DOWN]  | j0[JOY_DOWN]  | j1[JOY_DOWN];
		left  = f[BTN_LEFT]  | j0[JOY_LEFT]  | j1[JOY_LEFT];
		right = f[BTN_RIGHT] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		w.up          = rot ? left : up;
		w.down        = rot ? right : down;
		w.left        = rot ? down : left;
		w.right       = rot ? up : right;
		w.fire        = f[BTN_FIRE1] | j0[JOY_FIRE1] | j1[JOY_FIRE1];
		w.coin        = f[BTN_COIN];
		w.one_player  = f[BTN_ONE_PLAYER];
		w.two_players = f[BTN_TWO_PLAYERS];
		return core_buttons_t'(~w); // Pressed reads low
	endfunction

	// ==================================================
	// Reference model
	// ==================================================
	always @(posedge clk_sys) begin
		if (reset) begin
			pix_k = 0;
			snd_k = 0;
			{exp_pix, exp_star, exp_snd, exp_core_reset} = '0;
			{exp_r, exp_g, exp_b, exp_hs, exp_vs} = '0;
			acc_model = '0;
		end else begin
			if (exp_pix) begin  // Strobe high before this edge
				exp_r  = (core_hblank | core_vblank) ? '0 : {core_r, core_r};
				exp_g  = (core_hblank | core_vblank) ? '0 : {core_g, core_g};
				exp_b  = (core_hblank | core_vblank) ? '0 : {core_b, core_b};
				exp_hs = core_hs;
				exp_vs = core_vs;
			end
			exp_pix  = (pix_k == 0);
			exp_star = (pix_k == STAR_PHASE_A) || (pix_k == STAR_PHASE_B);
			exp_snd  = (snd_k == SND_DIV - 1);
			pix_k = (pix_k + 1) % PIX_DIV;
			snd_k = (snd_k + 1) % SND_DIV;
			exp_core_reset = reset_req | menu_reset;
			acc_model = {1'b0, acc_model[AUDIO_W-1:0]} + {1'b0, audio_in};
		end
	end

	// ==================================================
	// Tests, each entered and left on a falling edge
	// ==================================================
	task automatic send_key();
		ps2_key_t rec;
		rec.toggle   = ~ps2_key.toggle;
		rec.pressed  = 1'(take_bits(1));
		rec.extended = 1'(take_bits(1));
		if (take_bits(2) != 0)
			rec.code = code_for(int'(take_bits(4)) % NUM_BUTTONS);
		else
			rec.code = 8'(take_bits(8)); // Mostly unknown codes
		ps2_key = rec;
		for (int i = 0; i < NUM_BUTTONS; i++)
			if (code_for(i) == rec.code)
				flags[i] = rec.pressed;
		repeat (3) @(negedge clk_sys);
		compare_buttons("core_buttons", core_buttons, expected_buttons(flags, joy0, joy1, rotate));
	endtask

	task automatic check_audio();
		int     count;
		audio_t level;
		level = audio_t'(take_bits(AUDIO_W));
		audio_in = level;
		reset = 1'b1;
		flags = '0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		count = 0;
		repeat (1024) begin
			@(negedge clk_sys);
			compare_bit("audio_l", audio_l, acc_model[AUDIO_W]);
			compare_bit("audio_r", audio_r, acc_model[AUDIO_W]);
			count += int'(audio_l);
		end
		compare_count("audio_l ones", count, int'(level));
	endtask

	initial begin
		lfsr = 16'd17;
		reset = 1'b1;
		{reset_req, menu_reset, rotate} = '0;
		ps2_key = '0;
		joy0 = '0;
		joy1 = '0;
		{core_r, core_g, core_b} = '0;
		{core_hs, core_vs, core_hblank, core_vblank} = '0;
		audio_in = '0;
		flags = '0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		repeat (240) begin
			@(negedge clk_sys);
			compare_bit("ce_pix", ce_pix, exp_pix);
			compare_bit("ce_star", ce_star, exp_star);
			compare_bit("ce_snd", ce_snd, exp_snd);
		end

		repeat (200) send_key();

		repeat (100) begin  // Joystick merge and rotation
			joy0 = joy_t'(take_bits(8));
			joy1 = joy_t'(take_bits(8));
			rotate = 1'(take_bits(1));
			@(negedge clk_sys);
			compare_buttons("core_buttons", core_buttons,
				expected_buttons(flags, joy0, joy1, rotate));
		end

		repeat (300) begin
			core_r = core_color_t'(take_bits(CORE_COLOR_W));
			core_g = core_color_t'(take_bits(CORE_COLOR_W));
			core_b = core_color_t'(take_bits(CORE_COLOR_W));
			core_hs = 1'(take_bits(1));
			core_vs = 1'(take_bits(1));
			core_hblank = (take_bits(2) == 0);
			core_vblank = (take_bits(3) == 0);
			@(negedge clk_sys);
			compare_bit("ce_pix", ce_pix, exp_pix);
			compare_color("vga_r", vga_r, exp_r);
			compare_color("vga_g", vga_g, exp_g);
			compare_color("vga_b", vga_b, exp_b);
			compare_bit("vga_hs", vga_hs, exp_hs);
			compare_bit("vga_vs", vga_vs, exp_vs);
		end

		repeat (3) check_audio();

		repeat (100) begin
			reset_req = 1'(take_bits(1));
			menu_reset = 1'(take_bits(1));
			@(negedge clk_sys);
			compare_bit("core_reset", core_reset, exp_core_reset);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

	// Twice the summed test length
	initial begin
		#(2 * TEST_CYCLES * 10);
		$display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
		report_failure();
	end

endmodule

//--- tb/arcade_io_props.sv
module arcade_io_props #(
	parameter bit CHECK_EXCL = 1'b1  // Instance has a second strobe to keep apart
) (
	input logic clk_sys,
	input logic reset,
	input logic pulse,  // Strobe that must stay one cycle wide
	input logic excl    // Strobe that may never meet pulse
);

	// ==================================================
	// Strobe shape
	// ==================================================
	single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		pulse |=> !pulse)
		else $error("strobe high on two consecutive cycles");

	// Star phases sit between pixel strobes
	if (CHECK_EXCL) begin : g_excl
		no_overlap: assert property (@(posedge clk_sys) disable iff (reset)
			!(pulse && excl))
			else $error("two exclusive strobes high in the same cycle");
	end

endmodule

bind clk_enables arcade_io_props u_enable_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.pulse   (ce_pix),
	.excl    (ce_star)
);

bind ps2_key_decoder arcade_io_props #(.CHECK_EXCL(1'b0)) u_key_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.pulse   (key_evt),
	.excl    (1'b0)
);

//--- hdl/arcade_io_top.sv
module arcade_io_top
	import arcade_input_pkg::*, arcade_av_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          reset_req,
	input  logic          menu_reset,
	input  logic          rotate,
	input  ps2_key_t      ps2_key,
	input  joy_t          joy0,
	input  joy_t          joy1,
	input  core_color_t   core_r,
	input  core_color_t   core_g,
	input  core_color_t   core_b,
	input  logic          core_hs,
	input  logic          core_vs,
	input  logic          core_hblank,
	input  logic          core_vblank,
	input  audio_t        audio_in,
	output logic          ce_pix,
	output logic          ce_star,
	output logic          ce_snd,
	output core_buttons_t core_buttons,
	output logic          core_reset,
	output out_color_t    vga_r,
	output out_color_t    vga_g,
	output out_color_t    vga_b,
	output logic          vga_hs,
	output logic          vga_vs,
	output logic          audio_l,
	output logic          audio_r
);

	logic        key_evt;
	button_e     key_btn;
	logic        key_pressed;
	button_vec_t btn_state;

	// ==================================================
	// Timing and reset
	// ==================================================
	clk_enables u_clk_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.ce_star (ce_star),
		.ce_snd  (ce_snd)
	);

	always_ff @(posedge clk_sys) begin
		if (reset)
			core_reset <= 1'b0;
		else
			core_reset <= reset_req | menu_reset; // Button or OSD request
	end

	// ==================================================
	// Controls
	// ==================================================
	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.key_evt     (key_evt),
		.key_btn     (key_btn),
		.key_pressed (key_pressed)
	);

	button_latch u_button_latch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_evt     (key_evt),
		.key_btn     (key_btn),
		.key_pressed (key_pressed),
		.btn_state   (btn_state)
	);

	control_mapper u_control_mapper (
		.btn_state    (btn_state),
		.joy0         (joy0),
		.joy1         (joy1),
		.rotate       (rotate),
		.core_buttons (core_buttons)
	);

	// ==================================================
	// Video and audio
	// ==================================================
	video_blank u_video_blank (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ce_pix      (ce_pix),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.core_hs     (core_hs),
		.core_vs     (core_vs),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.audio_in  (audio_in),
		.audio_out (audio_l)
	);

	assign audio_r = audio_l; // Mono core

endmodule

//--- hdl/sigma_delta_dac.sv
module sigma_delta_dac
	import arcade_av_pkg::*;
(
	input  logic   clk_sys,
	input  logic   reset,
	input  audio_t audio_in,
	output logic   audio_out
);

	// ==================================================
	// First-order modulator
	// ==================================================
	logic [AUDIO_W:0] acc; // Top bit holds the last carry

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[AUDIO_W-1:0]} + {1'b0, audio_in};
	end

	// Carry density equals audio_in / 2**AUDIO_W
	assign audio_out = acc[AUDIO_W];

endmodule

//--- hdl/video_blank.sv
module video_blank
	import arcade_av_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ce_pix,
	input  core_color_t core_r,
	input  core_color_t core_g,
	input  core_color_t core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic        core_hblank,
	input  logic        core_vblank,
	output out_color_t  vga_r,
	output out_color_t  vga_g,
	output out_color_t  vga_b,
	output logic        vga_hs,
	output logic        vga_vs
);

	logic blank;

	assign blank = core_hblank | core_vblank;

	// Replicate the narrow colour to full scale, black in blanking
	function automatic out_color_t expand(input core_color_t c, input logic blk);
		return blk ? '0 : {(OUT_COLOR_W / CORE_COLOR_W){c}};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (ce_pix) begin
			vga_r  <= expand(core_r, blank);
			vga_g  <= expand(core_g, blank);
			vga_b  <= expand(core_b, blank);
			vga_hs <= core_hs; // Syncs unchanged
			vga_vs <= core_vs;
		end
	end

endmodule

//--- hdl/control_mapper.sv
module control_mapper
	import arcade_input_pkg::*;
(
	input  button_vec_t   btn_state,
	input  joy_t          joy0,
	input  joy_t          joy1,
	input  logic          rotate,
	output core_buttons_t core_buttons
);

	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;
	core_buttons_t active;   // Active-high form before inversion

	// Keyboard and both joysticks merged
	assign m_up    = btn_state[BTN_UP]    | joy0[JOY_UP]    | joy1[JOY_UP];
	assign m_down  = btn_state[BTN_DOWN]  | joy0[JOY_DOWN]  | joy1[JOY_DOWN];
	assign m_left  = btn_state[BTN_LEFT]  | joy0[JOY_LEFT]  | joy1[JOY_LEFT];
	assign m_right = btn_state[BTN_RIGHT] | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];
	assign m_fire  = btn_state[BTN_FIRE1] | joy0[JOY_FIRE1] | joy1[JOY_FIRE1];

	always_comb begin
		active = '0;

		// Rotated cabinet turns the stick a quarter
		if (rotate) begin
			active.up    = m_left;
			active.down  = m_right;
			active.left  = m_down;
			active.right = m_up;
		end else begin
			active.up    = m_up;
			active.down  = m_down;
			active.left  = m_left;
			active.right = m_right;
		end

		active.fire        = m_fire;
		active.coin        = btn_state[BTN_COIN];
		active.one_player  = btn_state[BTN_ONE_PLAYER];
		active.two_players = btn_state[BTN_TWO_PLAYERS];
	end

	// Core inputs are pulled up, pressed reads low
	assign core_buttons = core_buttons_t'(~active);

endmodule

//--- hdl/button_latch.sv
module button_latch
	import arcade_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        key_evt,
	input  button_e     key_btn,
	input  logic        key_pressed,
	output button_vec_t btn_state
);

	// ==================================================
	// Held button flags
	// ==================================================

	// Make and break codes each touch a single flag
	always_ff @(posedge clk_sys) begin
		if (reset)
			btn_state <= '0; // Everything released
		else if (key_evt)
			btn_state[key_btn] <= key_pressed;
	end

endmodule

//--- hdl/ps2_key_decoder.sv
module ps2_key_decoder
	import arcade_input_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  ps2_key_t ps2_key,
	output logic     key_evt,
	output button_e  key_btn,
	output logic     key_pressed
);

	ps2_key_t key_q;     // Input sampled once
	logic     toggle_q;  // Toggle seen on the previous record
	logic     new_rec;
	logic     hit;
	button_e  btn;

	// Input register
	always_ff @(posedge clk_sys)
		key_q <= ps2_key;

	assign new_rec = (key_q.toggle != toggle_q);

	// Scan code lookup
	always_comb begin
		hit = 1'b1;
		btn = BTN_UP;
		case (key_q.code)
			KEY_UP:    btn = BTN_UP;
			KEY_DOWN:  btn = BTN_DOWN;
			KEY_LEFT:  btn = BTN_LEFT;
			KEY_RIGHT: btn = BTN_RIGHT;
			KEY_ESC:   btn = BTN_COIN;
			KEY_F1:    btn = BTN_ONE_PLAYER;
			KEY_F2:    btn = BTN_TWO_PLAYERS;
			KEY_SPACE: btn = BTN_FIRE1;
			KEY_ALT:   btn = BTN_FIRE2;
			KEY_CTRL:  btn = BTN_FIRE3;
			default:   hit = 1'b0; // Unknown key is ignored
		endcase
	end

	// Event on a toggle change with a known code
	always_ff @(posedge clk_sys) begin
		toggle_q <= key_q.toggle;
		if (reset)
			key_evt <= 1'b0;
		else
			key_evt <= new_rec && hit;
	end

	always_ff @(posedge clk_sys) begin
		if (new_rec) begin
			key_btn     <= btn;
			key_pressed <= key_q.pressed;
		end
	end

endmodule

//--- hdl/clk_enables.sv
module clk_enables
	import arcade_av_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	output logic ce_pix,
	output logic ce_star,
	output logic ce_snd
);

	logic [PIX_CNT_W-1:0] pix_cnt;
	logic [SND_CNT_W-1:0] snd_cnt;

	// Free-running dividers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix_cnt <= '0;
			snd_cnt <= '0;
		end else begin
			if (pix_cnt == PIX_CNT_W'(PIX_DIV - 1))
				pix_cnt <= '0;
			else
				pix_cnt <= pix_cnt + 1'b1;

			if (snd_cnt == SND_CNT_W'(SND_DIV - 1))
				snd_cnt <= '0;
			else
				snd_cnt <= snd_cnt + 1'b1;
		end
	end

	// Strobes decoded from the counts, one cycle wide
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_pix  <= 1'b0;
			ce_star <= 1'b0;
			ce_snd  <= 1'b0;
		end else begin
			ce_pix  <= (pix_cnt == '0);
			ce_star <= (pix_cnt == PIX_CNT_W'(STAR_PHASE_A)) ||
			           (pix_cnt == PIX_CNT_W'(STAR_PHASE_B)); // Two star phases per pixel
			ce_snd  <= (snd_cnt == SND_CNT_W'(SND_DIV - 1));
		end
	end

endmodule

//--- hdl/arcade_av_pkg.sv
package arcade_av_pkg;

	// ==================================================
	// Video and audio widths
	// ==================================================
	localparam int CORE_COLOR_W = 3;
	localparam int OUT_COLOR_W  = 6;
	localparam int AUDIO_W      = 10;

	typedef logic [CORE_COLOR_W-1:0] core_color_t;
	typedef logic [OUT_COLOR_W-1:0]  out_color_t;
	typedef logic [AUDIO_W-1:0]      audio_t;

	// ==================================================
	// Clock enable dividers
	// ==================================================
	localparam int PIX_DIV      = 6;  // Pixel rate from clk_sys
	localparam int STAR_PHASE_A = 3;
	localparam int STAR_PHASE_B = 5;
	localparam int SND_DIV      = 20; // Sound CPU rate

	localparam int PIX_CNT_W = $clog2(PIX_DIV);
	localparam int SND_CNT_W = $clog2(SND_DIV);

endpackage

//--- hdl/arcade_input_pkg.sv
package arcade_input_pkg;

	// ==================================================
	// Keyboard buttons
	// ==================================================
	typedef enum logic [3:0] {
		BTN_UP,
		BTN_DOWN,
		BTN_LEFT,
		BTN_RIGHT,
		BTN_COIN,
		BTN_ONE_PLAYER,
		BTN_TWO_PLAYERS,
		BTN_FIRE1,
		BTN_FIRE2,
		BTN_FIRE3
	} button_e;

	localparam int NUM_BUTTONS = 10;

	typedef logic [NUM_BUTTONS-1:0] button_vec_t; // One flag per button_e

	// Record from the PS/2 side
	typedef struct packed {
		logic       toggle;   // Flips on every new record
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Set 2 scan codes
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_ESC   = 8'h76;
	localparam logic [7:0] KEY_F1    = 8'h05;
	localparam logic [7:0] KEY_F2    = 8'h06;
	localparam logic [7:0] KEY_CTRL  = 8'h14;
	localparam logic [7:0] KEY_ALT   = 8'h11;
	localparam logic [7:0] KEY_SPACE = 8'h29;

	// ==================================================
	// Joystick and core button word
	// ==================================================
	typedef logic [7:0] joy_t; // Bit 5 is fire2, not used by this core

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;

	// Active low at the core
	typedef struct packed {
		logic two_players;
		logic fire;
		logic coin;
		logic one_player;
		logic right;
		logic left;
		logic down;
		logic up;
	} core_buttons_t;

endpackage
